/* sources.f */
+incdir+hw
hw/exc_pkg.sv
hw/dbg_stop_reg.sv
hw/exc_controller.sv
hw/exc_pc_unit.sv
hw/exc_top.sv
test/tb_exc_top.sv

/* Makefile */
# Verilator build, run and lint for the exception slice

VERILATOR  ?= verilator
VFLAGS     = --binary --timing -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_exc_top
RTL_TOP    = exc_top
FILELIST   = sources.f
LOG        = sim.log
BIN        = obj_dir/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BIN) | tee $(LOG)
	@if grep -q "TB FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TB PASSED" $(LOG) || (echo "simulation ended without a verdict"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

/* test/exc_testdata.txt */
// cols: ctl_a ctl_b pc_if pc_id flags misc exc_pc epc, one nibble per flag
// ctl_a fe,busy,drop,dflush,step,irq,irq_nm,irq_en  ctl_b jid,jex,stall,ill,trap,clr,we,wdata
// flags sel,mux,save_if,save_id,irq_present,trap,flush,pc_valid  misc hwloop,dsr
// idle, then illegal insn with iie clear and its return
10000000_00000000_00001000_00000ffc_00000001_10000000_00000000_00000000
10000000_00010000_00001004_00001000_11010001_10000000_00000100_00000000
10000000_00000000_00000100_000000fc_00000001_10000000_00000000_00001000
10000000_00000100_00000104_00000100_00000001_10000000_00000000_00001000
10000000_00000000_00001004_00001000_00000001_10000000_00000000_00001000
// irq with no jump, nested irq ignored, return with fetch off, then nmi
10000101_00000000_00002000_00001ffc_12101001_10000000_00000104_00001000
10000101_00000000_00000104_00000100_00001001_10000000_00000000_00002000
00000000_00000100_00000108_00000104_00000011_10000000_00000000_00002000
10000011_00000000_00003000_00002ffc_13101001_10000000_00000108_00002000
10000000_00000100_0000010c_00000108_00000001_10000000_00000000_00003000
// irq while a jump sits in id, vector taken one cycle later
10000101_10000000_00004000_00003ffc_00001001_10000000_00000000_00003000
10000101_00000000_00004004_00004000_12101001_10000000_00000104_00003000
10000101_00000000_00000104_00000100_00001001_10000000_00000000_00004004
10000000_00000100_00000108_00000104_00000001_10000000_00000000_00004004
// stop register redirection and the other trap sources
10000000_00000011_00004008_00004004_00000001_10000000_00000000_00004004
10000000_00010000_0000400c_00004008_00000101_11000000_00000000_00004004
10000000_00000012_00004010_0000400c_00000001_11000000_00000000_00004004
10000101_00000000_00004014_00004010_00001101_12000000_00000000_00004004
10000000_00001000_00004018_00004014_00000101_12000000_00000000_00004004
10001000_00000000_0000401c_00004018_00000101_12000000_00000000_00004004
10010000_00000000_00004020_0000401c_00000101_12000000_00000000_00004004
10000000_00000010_00004024_00004020_00000001_12000000_00000000_00004004
// return outside a handler takes the illegal vector
10000000_00000100_00005004_00005000_11010001_10000000_00000100_00004004
10000000_00000000_00005008_00005004_00000001_10000000_00000000_00005000
// stall and drop hold state, busy and irq enable
10000000_00110000_0000500c_00006000_11010001_10000000_00000100_00005000
10000000_00100000_0000500c_00006000_00000001_10000000_00000000_00005000
10100000_00010000_0000500c_00006000_00000001_10000000_00000000_00005000
10000000_00010000_00007004_00007000_11010001_10000000_00000100_00005000
11000000_00000000_00007008_00007004_00000001_00000000_00000000_00007000
10000100_00000000_0000700c_00007008_00000001_10000000_00000000_00007000
10000000_00100100_00007010_0000700c_00000001_10000000_00000000_00007000
00000000_00000100_00007014_00007010_00000011_10000000_00000000_00007000
10100101_00000000_00007018_00007014_00001001_10000000_00000000_00007000
10000101_00000000_0000701c_00007018_12101001_10000000_00000104_00007000
10000000_00000000_00000104_00000100_00000001_10000000_00000000_0000701c

/* test/tb_exc_top.sv */
//////////////////////////////////////////////////
// testbench for the exception slice top
// replays one data file row per cycle and checks
// every output at the falling edge
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_exc_top
  import exc_pkg::*;
();

  localparam int MAX_ROWS        = 64;
  localparam int RESET_CYCLES    = 8;
  localparam int WATCHDOG_CYCLES = 2000;  // whole run must fit in this

  // one data line in file column order with one nibble per flag
  typedef struct packed {
    logic [31:0] ctl_a;      // fe busy drop dflush step irq irq_nm irq_en
    logic [31:0] ctl_b;      // jmp_id jmp_ex stall ill trap clr dsr_we dsr_wdata
    pc_t         pc_if;
    pc_t         pc_id;
    logic [31:0] exp_flags;  // sel mux save_if save_id irq_present trap flush pc_valid
    logic [31:0] exp_misc;   // hwloop and dsr in the top nibbles
    pc_t         exp_exc_pc;
    pc_t         exp_epc;    // value after the previous edge
  } row_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       fetch_enable, core_busy, drop_instruction, dbg_flush_pipe, dbg_st_en;
  irq_req_t   irq;
  id_status_t id_status;
  logic       dsr_we;
  dsr_t       dsr_wdata;
  pc_t        pc_if, pc_id;
  exc_req_t   exc_req;
  dsr_t       dsr;
  logic       irq_present, trap_hit, exc_pipe_flush, pc_valid, hwloop_enable;
  pc_t        exc_pc, epc;

  logic [$bits(row_t)-1:0] rows [0:MAX_ROWS-1];
  int n_rows;
  int cur_row;
  int errors;

  always #4 clk = ~clk;  // 8 ns period

  exc_top dut_i (
    .clk (clk), .rst_n (rst_n),
    .fetch_enable_i (fetch_enable), .core_busy_i (core_busy),
    .drop_instruction_i (drop_instruction), .dbg_flush_pipe_i (dbg_flush_pipe),
    .dbg_st_en_i (dbg_st_en), .irq_i (irq), .id_status_i (id_status),
    .dsr_we_i (dsr_we), .dsr_wdata_i (dsr_wdata),
    .pc_if_i (pc_if), .pc_id_i (pc_id),
    .exc_req_o (exc_req), .dsr_o (dsr),
    .irq_present_o (irq_present), .trap_hit_o (trap_hit),
    .exc_pipe_flush_o (exc_pipe_flush), .pc_valid_o (pc_valid),
    .hwloop_enable_o (hwloop_enable), .exc_pc_o (exc_pc), .epc_o (epc)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // marks unused memory so the row count stops there
  function automatic logic [$bits(row_t)-1:0] fill_row(input int idx);
    return {8{32'hdead_beef ^ idx}};
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    if (act_val !== exp_val)
    begin
      errors++;
      $display("** Error row %0d: %s expected %h actual %h", cur_row, name, exp_val, act_val);
    end
  endtask

  task automatic apply_row(input row_t r);
    fetch_enable                  <= r.ctl_a[28];
    core_busy                     <= r.ctl_a[24];
    drop_instruction              <= r.ctl_a[20];
    dbg_flush_pipe                <= r.ctl_a[16];
    dbg_st_en                     <= r.ctl_a[12];
    irq.irq                       <= r.ctl_a[8];
    irq.irq_nm                    <= r.ctl_a[4];
    irq.irq_enable                <= r.ctl_a[0];
    id_status.jump_in_id          <= r.ctl_b[29:28];
    id_status.jump_in_ex          <= r.ctl_b[25:24];
    id_status.stall_id            <= r.ctl_b[20];
    id_status.illegal_insn        <= r.ctl_b[16];
    id_status.trap_insn           <= r.ctl_b[12];
    id_status.clear_isr_running   <= r.ctl_b[8];
    dsr_we                        <= r.ctl_b[4];
    dsr_wdata                     <= r.ctl_b[1:0];
    pc_if                         <= r.pc_if;
    pc_id                         <= r.pc_id;
  endtask

  task automatic check_row(input row_t r);
    check_value("exc_pc_sel", 32'(r.exp_flags[31:28]), 32'(exc_req.pc_sel));
    check_value("exc_pc_mux", 32'(r.exp_flags[27:24]), 32'(exc_req.pc_mux));
    check_value("save_pc_if", 32'(r.exp_flags[23:20]), 32'(exc_req.save_pc_if));
    check_value("save_pc_id", 32'(r.exp_flags[19:16]), 32'(exc_req.save_pc_id));
    check_value("irq_present_o", 32'(r.exp_flags[15:12]), 32'(irq_present));
    check_value("trap_hit_o", 32'(r.exp_flags[11:8]), 32'(trap_hit));
    check_value("exc_pipe_flush_o", 32'(r.exp_flags[7:4]), 32'(exc_pipe_flush));
    check_value("pc_valid_o", 32'(r.exp_flags[3:0]), 32'(pc_valid));
    check_value("hwloop_enable_o", 32'(r.exp_misc[31:28]), 32'(hwloop_enable));
    check_value("dsr_o", 32'(r.exp_misc[27:24]), 32'(dsr));
    check_value("exc_pc_o", r.exp_exc_pc, exc_pc);
    check_value("epc_o", r.exp_epc, epc);
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial
  begin
    int   i;
    row_t cur;
    rst_n = 1'b0;
    fetch_enable = 1'b0;
    core_busy = 1'b0;
    drop_instruction = 1'b0;
    dbg_flush_pipe = 1'b0;
    dbg_st_en = 1'b0;
    irq = '0;
    id_status = '0;
    dsr_we = 1'b0;
    dsr_wdata = '0;
    pc_if = '0;
    pc_id = '0;
    errors = 0;
    cur_row = 0;
    for (i = 0; i < MAX_ROWS; i++)
      rows[i] = fill_row(i);
    $readmemh("test/exc_testdata.txt", rows);
    n_rows = 0;
    while (n_rows < MAX_ROWS && rows[n_rows] != fill_row(n_rows))
      n_rows++;
    if (n_rows == 0)
    begin
      errors++;
      $display("no stimulus rows found in test/exc_testdata.txt");
    end

    for (i = 0; i < RESET_CYCLES - 1; i++)
      @(posedge clk);
    @(negedge clk);                           // reset values while reset is held
    check_value("exc_pc_sel", 32'h0, 32'(exc_req.pc_sel));
    check_value("save_pc_if", 32'h0, 32'(exc_req.save_pc_if));
    check_value("save_pc_id", 32'h0, 32'(exc_req.save_pc_id));
    check_value("pc_valid_o", 32'h1, 32'(pc_valid));
    check_value("dsr_o", 32'h0, 32'(dsr));
    check_value("epc_o", 32'h0, epc);
    @(posedge clk);
    rst_n <= 1'b1;                            // released at the 8th edge

    i = 0;
    while (cur_row < n_rows && i < MAX_ROWS)  // one row per cycle
    begin
      cur = rows[cur_row];
      @(posedge clk);
      apply_row(cur);
      @(negedge clk);
      check_row(cur);
      cur_row++;
      i++;
    end
    if (cur_row < n_rows)
    begin
      errors++;
      $display("row loop stopped after %0d of %0d rows", cur_row, n_rows);
    end

    $display("tb_exc_top done: %0d rows checked, %0d errors", cur_row, errors);
    if (errors == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // watchdog for a run that never reaches the end
  initial
  begin
    int k;
    for (k = 0; k < WATCHDOG_CYCLES; k++)
      @(posedge clk);
    $display("simulation still running after %0d cycles", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

/* hw/exc_top.sv */
//////////////////////////////////////////////////
// exception slice top
// stop register, controller and pc unit
//////////////////////////////////////////////////

`timescale 1ns/1ps

module exc_top
  import exc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       fetch_enable_i,
  input  logic       core_busy_i,
  input  logic       drop_instruction_i,
  input  logic       dbg_flush_pipe_i,
  input  logic       dbg_st_en_i,
  input  irq_req_t   irq_i,
  input  id_status_t id_status_i,
  input  logic       dsr_we_i,
  input  dsr_t       dsr_wdata_i,
  input  pc_t        pc_if_i,
  input  pc_t        pc_id_i,
  output exc_req_t   exc_req_o,    // controller request, for observation
  output dsr_t       dsr_o,
  output logic       irq_present_o,
  output logic       trap_hit_o,
  output logic       exc_pipe_flush_o,
  output logic       pc_valid_o,
  output logic       hwloop_enable_o,
  output pc_t        exc_pc_o,
  output pc_t        epc_o
);

  dsr_t     dsr;
  exc_req_t exc_req;

  dbg_stop_reg u_dsr (
    .clk         (clk),
    .rst_n       (rst_n),
    .dsr_we_i    (dsr_we_i),
    .dsr_wdata_i (dsr_wdata_i),
    .dsr_o       (dsr)
  );

  exc_controller u_ctrl (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_enable_i     (fetch_enable_i),
    .core_busy_i        (core_busy_i),
    .drop_instruction_i (drop_instruction_i),
    .dbg_flush_pipe_i   (dbg_flush_pipe_i),
    .dbg_st_en_i        (dbg_st_en_i),
    .irq_i              (irq_i),
    .id_status_i        (id_status_i),
    .dsr_i              (dsr),
    .exc_req_o          (exc_req),
    .irq_present_o      (irq_present_o),
    .trap_hit_o         (trap_hit_o),
    .exc_pipe_flush_o   (exc_pipe_flush_o),
    .pc_valid_o         (pc_valid_o),
    .hwloop_enable_o    (hwloop_enable_o)
  );

  // stall bit of the decode status freezes the epc too
  exc_pc_unit u_pc (
    .clk                (clk),
    .rst_n              (rst_n),
    .exc_req_i          (exc_req),
    .stall_id_i         (id_status_i.stall_id),
    .drop_instruction_i (drop_instruction_i),
    .pc_if_i            (pc_if_i),
    .pc_id_i            (pc_id_i),
    .exc_pc_o           (exc_pc_o),
    .epc_o              (epc_o)
  );

  assign exc_req_o = exc_req;
  assign dsr_o     = dsr;

endmodule

/* hw/exc_pc_unit.sv */
//////////////////////////////////////////////////
// exception pc unit
// handler address mux and saved exception pc
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "exc_cfg.svh"

module exc_pc_unit
  import exc_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  exc_req_t exc_req_i,          // from the controller
  input  logic     stall_id_i,
  input  logic     drop_instruction_i,
  input  pc_t      pc_if_i,            // pc in fetch
  input  pc_t      pc_id_i,            // pc in decode
  output pc_t      exc_pc_o,           // handler address
  output pc_t      epc_o               // saved return pc
);

  pc_t  epc_q;
  logic advance;
  logic save_if;
  logic save_id;

  // vector select to handler address
  always_comb
  begin
    case (exc_req_i.pc_mux)
      `EXC_PC_ILLINSN: exc_pc_o = `EXC_VEC_ILLINSN;
      `EXC_PC_IRQ:     exc_pc_o = `EXC_VEC_IRQ;
      `EXC_PC_IRQ_NM:  exc_pc_o = `EXC_VEC_IRQ_NM;
      default:         exc_pc_o = '0;  // no exception
    endcase
  end

  // strobes only count on an advancing cycle
  assign advance = !stall_id_i && !drop_instruction_i;
  assign save_if = exc_req_i.save_pc_if && advance;
  assign save_id = exc_req_i.save_pc_id && advance;

  //////////////////////////////////////////////////
  // exception pc register
  //////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      epc_q <= '0;
    end
    else if (save_if)
    begin
      epc_q <= pc_if_i;  // interrupt returns to fetched insn
    end
    else if (save_id)
    begin
      epc_q <= pc_id_i;  // illegal insn points at itself
    end
  end

  assign epc_o = epc_q;

endmodule

/* hw/exc_controller.sv */
//////////////////////////////////////////////////
// exception controller
// picks the highest priority exception, waits out
// a pending delay slot and blocks nesting
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "exc_cfg.svh"

module exc_controller
  import exc_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       fetch_enable_i,
  input  logic       core_busy_i,
  input  logic       drop_instruction_i, // mispredict, squash this cycle
  input  logic       dbg_flush_pipe_i,   // debug halt request
  input  logic       dbg_st_en_i,        // single-step
  input  irq_req_t   irq_i,
  input  id_status_t id_status_i,
  input  dsr_t       dsr_i,
  output exc_req_t   exc_req_o,          // to the pc unit
  output logic       irq_present_o,
  output logic       trap_hit_o,
  output logic       exc_pipe_flush_o,   // flush and go back to sleep
  output logic       pc_valid_o,
  output logic       hwloop_enable_o
);

  typedef enum logic [0:0] {Idle, NopDelayIR} fsm_state_e;
  typedef enum logic [1:0] {ExcNone, ExcIR, ExcIllegalInsn} exc_reason_e;

  fsm_state_e  state_q, state_d;
  exc_reason_e reason_q, reason_d;  // latched reason
  exc_reason_e reason;              // decoded this cycle
  logic        running_q, running_d; // inside a handler
  logic        clear_reason;
  logic        advance;              // registers move this edge
  exc_sel_t    irq_vec;

  assign advance         = !id_status_i.stall_id && !drop_instruction_i;
  assign hwloop_enable_o = !core_busy_i;
  assign irq_present_o   = (irq_i.irq || irq_i.irq_nm) && irq_i.irq_enable;

  // non-maskable line wins the vector
  assign irq_vec = irq_i.irq_nm ? `EXC_PC_IRQ_NM : `EXC_PC_IRQ;

  // events that go to the debug unit instead
  assign trap_hit_o = id_status_i.trap_insn
                   || dbg_flush_pipe_i
                   || dbg_st_en_i
                   || (id_status_i.illegal_insn && dsr_i[`DSR_IIE])
                   || (irq_present_o && dsr_i[`DSR_INTE] && !running_q);

  //////////////////////////////////////////////////
  // priority decode
  //////////////////////////////////////////////////

  always_comb
  begin
    reason           = ExcNone;
    exc_pipe_flush_o = 1'b0;

    if (id_status_i.illegal_insn)
    begin
      // debug takes it when iie is set, no nesting either
      if (!dsr_i[`DSR_IIE] && !running_q)
        reason = ExcIllegalInsn;
    end
    else if (irq_present_o && !running_q)
    begin
      if (!dsr_i[`DSR_INTE])  // inte set hands it to debug
        reason = ExcIR;
    end
    else if (id_status_i.clear_isr_running)
    begin
      if (running_q)
      begin
        // handler done, sleep if fetch is off
        if (!fetch_enable_i)
          exc_pipe_flush_o = 1'b1;
      end
      else
      begin
        reason = ExcIllegalInsn;  // return with no handler running
      end
    end
  end

  //////////////////////////////////////////////////
  // delay slot fsm
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d      = state_q;
    reason_d     = reason_q;
    running_d    = running_q;
    clear_reason = 1'b0;
    pc_valid_o   = 1'b1;
    exc_req_o.pc_sel     = 1'b0;
    exc_req_o.pc_mux     = `EXC_PC_NO_INCR;
    exc_req_o.save_pc_if = 1'b0;
    exc_req_o.save_pc_id = 1'b0;

    if (!drop_instruction_i)  // a drop keeps every output at default
    begin
      case (state_q)
        Idle:
        begin
          reason_d = reason;
          case (reason)
            ExcIR:
            begin
              if (id_status_i.jump_in_id == '0)
              begin
                exc_req_o.pc_sel     = 1'b1;
                exc_req_o.pc_mux     = irq_vec;
                exc_req_o.save_pc_if = 1'b1;  // resume at the fetched pc
                running_d            = 1'b1;
                clear_reason         = 1'b1;
              end
              else
              begin
                state_d = NopDelayIR;  // let the delay slot retire first
              end
            end
            ExcIllegalInsn:
            begin
              exc_req_o.pc_sel     = 1'b1;
              exc_req_o.pc_mux     = `EXC_PC_ILLINSN;
              exc_req_o.save_pc_id = 1'b1;  // faulting insn sits in id
              running_d            = 1'b1;
              clear_reason         = 1'b1;
            end
            default:
            begin
              state_d = Idle;
            end
          endcase
        end

        NopDelayIR:
        begin
          if (reason_q == ExcIR)
          begin
            exc_req_o.pc_sel     = 1'b1;
            exc_req_o.pc_mux     = irq_vec;
            exc_req_o.save_pc_if = 1'b1;
            running_d            = 1'b1;
          end
          clear_reason = 1'b1;
          state_d      = Idle;
        end

        default:
        begin
          state_d = Idle;
        end
      endcase
    end
  end

  // everything freezes on stall or drop
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q   <= Idle;
      reason_q  <= ExcNone;
      running_q <= 1'b0;
    end
    else if (advance)
    begin
      state_q   <= state_d;
      reason_q  <= clear_reason ? ExcNone : reason_d;
      running_q <= id_status_i.clear_isr_running ? 1'b0 : running_d;
    end
  end

endmodule

/* hw/dbg_stop_reg.sv */
//////////////////////////////////////////////////
// debug stop register
// holds the stop bits that hand illegal insns and
// interrupts over to the debug unit
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "exc_cfg.svh"

module dbg_stop_reg
  import exc_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  logic dsr_we_i,    // write strobe
  input  dsr_t dsr_wdata_i, // new stop bits
  output dsr_t dsr_o        // current stop bits
);

  dsr_t dsr_q;

  // both bits load on the strobe, nothing else touches them
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      dsr_q <= '0;  // no redirection after reset
    end
    else if (dsr_we_i)
    begin
      dsr_q[`DSR_INTE] <= dsr_wdata_i[`DSR_INTE]; // interrupt stop
      dsr_q[`DSR_IIE]  <= dsr_wdata_i[`DSR_IIE];  // illegal insn stop
    end
  end

  assign dsr_o = dsr_q;

endmodule

/* hw/exc_pkg.sv */
//////////////////////////////////////////////////
// exception slice types
// vector widths and the request / status bundles
//////////////////////////////////////////////////

`include "exc_cfg.svh"

package exc_pkg;

  typedef logic [`PC_W-1:0] pc_t;     // program counter value
  typedef logic [1:0]       exc_sel_t; // vector select code
  typedef logic [1:0]       jump_t;    // jump kind, zero is no jump
  typedef logic [1:0]       dsr_t;     // debug stop register

  typedef struct packed {
    logic irq;         // maskable request line
    logic irq_nm;      // non-maskable request line
    logic irq_enable;  // global enable
  } irq_req_t;

  typedef struct packed {
    jump_t jump_in_id;
    jump_t jump_in_ex;
    logic  stall_id;
    logic  illegal_insn;
    logic  trap_insn;
    logic  clear_isr_running;  // return from handler
  } id_status_t;

  // controller to pc unit
  typedef struct packed {
    logic     pc_sel;
    exc_sel_t pc_mux;
    logic     save_pc_if;
    logic     save_pc_id;
  } exc_req_t;

endpackage

/* hw/exc_cfg.svh */
//////////////////////////////////////////////////
// exception slice configuration
// stop register bits, vector select codes and
// fixed handler addresses
//////////////////////////////////////////////////

`ifndef EXC_CFG_SVH
`define EXC_CFG_SVH

// debug stop register bit positions
`define DSR_INTE 1  // interrupt goes to debug unit
`define DSR_IIE  0  // illegal instruction goes to debug unit

// vector select codes towards the pc unit
`define EXC_PC_NO_INCR 2'b00
`define EXC_PC_ILLINSN 2'b01
`define EXC_PC_IRQ     2'b10
`define EXC_PC_IRQ_NM  2'b11

`define PC_W 32

// handler entry points
`define EXC_VEC_ILLINSN 32'h0000_0100
`define EXC_VEC_IRQ     32'h0000_0104
`define EXC_VEC_IRQ_NM  32'h0000_0108

`endif
